/* design/softmax_params.svh */
`ifndef SOFTMAX_PARAMS_SVH
`define SOFTMAX_PARAMS_SVH

// vector geometry
`define SM_VEC_LEN   32
`define SM_WORDS     16

// exponential table, exp(0) = 1 << SM_EXP_FRAC
`define SM_EXP_FRAC  12
`define SM_EXP_DEPTH 16

// width of one probability byte
`define SM_OUT_BITS  8

`endif

/* design/softmax_pkg.sv */
`include "softmax_params.svh"

package softmax_pkg;

  // one word as it sits in the upstream / downstream fifo
  typedef logic [15:0] stream_word_t;

  // signed lane, holds a sign-extended byte or an exponential up to 4096
  typedef logic signed [15:0] lane_t;

  // whole vector, lane i at bits [16*i +: 16]
  typedef lane_t [`SM_VEC_LEN-1:0] vec_t;

  // sum of 32 exponentials, at most 32 * 4096
  typedef logic [17:0] sum_t;

  typedef logic [`SM_OUT_BITS-1:0] prob_t;

  // control opcodes, anything but bypass runs softmax
  typedef enum logic [1:0] {
    MODE_BYPASS  = 2'd0,
    MODE_SOFTMAX = 2'd1
  } mode_t;

endpackage

/* design/vec_if.sv */
`timescale 1ns/1ps

// one vector plus a side scalar between two pipeline stages
interface vec_if;

  logic                valid;
  logic                ready;
  softmax_pkg::vec_t   vec;
  softmax_pkg::sum_t   scalar;  // max or sum, depending on the link

  modport src (output valid, output vec, output scalar, input ready);
  modport dst (input valid, input vec, input scalar, output ready);

endinterface

/* design/softmax_in_collect.sv */
`timescale 1ns/1ps
`include "softmax_params.svh"

module softmax_in_collect (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      run,
  input  softmax_pkg::stream_word_t fifo_data,
  input  logic                      fifo_empty,
  output logic                      rd_en,
  vec_if.src                        out
);
  import softmax_pkg::*;

  vec_t       data;
  lane_t      lo_lane;
  lane_t      hi_lane;
  logic [3:0] cnt;   // word index inside the vector
  logic       full;  // vector complete and waiting for max_find

  assign lo_lane = {{8{fifo_data[7]}}, fifo_data[7:0]};
  assign hi_lane = {{8{fifo_data[15]}}, fifo_data[15:8]};

  // pop only while filling
  assign rd_en = run && !full && !fifo_empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      full <= 1'b0;
    end else if (rd_en) begin
      cnt <= cnt + 4'd1;
      if (cnt == 4'(`SM_WORDS - 1)) full <= 1'b1;
    end else if (out.valid && out.ready) begin
      full <= 1'b0;
    end
  end

  // low byte goes to the even lane
  always_ff @(posedge clk) begin
    if (rd_en) begin
      data[{cnt, 1'b0}] <= lo_lane;
      data[{cnt, 1'b1}] <= hi_lane;
    end
  end

  assign out.valid  = full;
  assign out.vec    = data;
  assign out.scalar = '0;

  // an offered vector stays put until max_find takes it
  a_hold_until_taken: assert property (@(posedge clk) disable iff (!rst_n)
    out.valid && !out.ready |=> out.valid && $stable(out.vec));

endmodule

/* design/softmax_max_find.sv */
`timescale 1ns/1ps
`include "softmax_params.svh"

module softmax_max_find (
  input  logic clk,
  input  logic rst_n,
  vec_if.dst   in,
  vec_if.src   out
);
  import softmax_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_HOLD
  } state_t;

  state_t     state;
  vec_t       data;
  lane_t      max_val;  // running maximum
  lane_t      cur;
  logic [4:0] idx;

  assign cur = data[idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        ST_IDLE: if (in.valid) begin
          state <= ST_SCAN;
          idx   <= '0;
        end
        ST_SCAN: begin
          idx <= idx + 5'd1;
          if (idx == 5'(`SM_VEC_LEN - 1)) state <= ST_HOLD;
        end
        ST_HOLD: if (out.ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // lane 0 seeds the max, then all 32 lanes are compared
  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      data    <= in.vec;
      max_val <= in.vec[0];
    end else if (state == ST_SCAN && cur > max_val) begin
      max_val <= cur;
    end
  end

  assign in.ready   = (state == ST_IDLE);
  assign out.valid  = (state == ST_HOLD);
  assign out.vec    = data;
  assign out.scalar = {{2{max_val[15]}}, max_val};  // sign-extended max

endmodule

/* design/softmax_exp_sum.sv */
`timescale 1ns/1ps
`include "softmax_params.svh"

module softmax_exp_sum (
  input  logic clk,
  input  logic rst_n,
  vec_if.dst   in,
  vec_if.src   out
);
  import softmax_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXP,
    ST_HOLD
  } state_t;

  state_t     state;
  vec_t       data;
  lane_t      mx;
  lane_t      diff;
  lane_t      exp_val;
  sum_t       sum;
  logic [4:0] idx;

  // round(4096 * e^-d), halves up
  function automatic lane_t exp_lut(input lane_t d);
    lane_t e;
    if (d >= lane_t'(`SM_EXP_DEPTH)) begin
      e = '0;
    end else begin
      case (d[3:0])
        4'd0:    e = 16'sd4096;
        4'd1:    e = 16'sd1507;
        4'd2:    e = 16'sd554;
        4'd3:    e = 16'sd204;
        4'd4:    e = 16'sd75;
        4'd5:    e = 16'sd28;
        4'd6:    e = 16'sd10;
        4'd7:    e = 16'sd4;
        4'd8:    e = 16'sd1;
        4'd9:    e = 16'sd1;
        default: e = '0;  // 10 and up round to zero
      endcase
    end
    return e;
  endfunction

  assign diff    = mx - data[idx];  // never negative, mx is the max
  assign exp_val = exp_lut(diff);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        ST_IDLE: if (in.valid) begin
          state <= ST_EXP;
          idx   <= '0;
        end
        ST_EXP: begin
          idx <= idx + 5'd1;
          if (idx == 5'(`SM_VEC_LEN - 1)) state <= ST_HOLD;
        end
        ST_HOLD: if (out.ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      data <= in.vec;
      mx   <= in.scalar[15:0];
      sum  <= '0;
    end else if (state == ST_EXP) begin
      data[idx] <= exp_val;  // lane now holds its exponential
      sum       <= sum + {2'b00, exp_val};
    end
  end

  assign in.ready   = (state == ST_IDLE);
  assign out.valid  = (state == ST_HOLD);
  assign out.vec    = data;
  assign out.scalar = sum;

endmodule

/* design/softmax_normalize.sv */
`timescale 1ns/1ps
`include "softmax_params.svh"

module softmax_normalize (
  input  logic clk,
  input  logic rst_n,
  vec_if.dst   in,
  vec_if.src   out
);
  import softmax_pkg::*;

  localparam int QBITS = `SM_OUT_BITS + 1;  // quotient can reach 256

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DIV,
    ST_HOLD
  } state_t;

  state_t           state;
  vec_t             data;
  sum_t             den;      // divisor, latched sum
  logic [4:0]       idx;
  logic [3:0]       bcnt;     // quotient bit counter
  logic [18:0]      rem;
  logic [18:0]      rem_cur;
  logic [18:0]      rem_sub;
  logic             q_bit;
  logic [QBITS-1:0] quo;
  logic [QBITS-1:0] quo_next;
  prob_t            prob;

  // restoring step, first bit starts from the raw exponential
  assign rem_cur  = (bcnt == 4'd0) ? {3'b000, data[idx]} : rem;
  assign q_bit    = (rem_cur >= {1'b0, den});
  assign rem_sub  = q_bit ? rem_cur - {1'b0, den} : rem_cur;
  assign quo_next = {quo[QBITS-2:0], q_bit};
  assign prob     = quo_next[QBITS-1] ? '1 : quo_next[QBITS-2:0];  // 256 saturates

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      idx   <= '0;
      bcnt  <= '0;
    end else begin
      case (state)
        ST_IDLE: if (in.valid) begin
          state <= ST_DIV;
          idx   <= '0;
          bcnt  <= '0;
        end
        ST_DIV: begin
          if (bcnt == 4'(QBITS - 1)) begin
            bcnt <= '0;
            idx  <= idx + 5'd1;
            if (idx == 5'(`SM_VEC_LEN - 1)) state <= ST_HOLD;
          end else begin
            bcnt <= bcnt + 4'd1;
          end
        end
        ST_HOLD: if (out.ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      data <= in.vec;
      den  <= in.scalar;
    end else if (state == ST_DIV) begin
      rem <= {rem_sub[17:0], 1'b0};
      quo <= quo_next;
      if (bcnt == 4'(QBITS - 1)) data[idx] <= {8'd0, prob};
    end
  end

  assign in.ready   = (state == ST_IDLE);
  assign out.valid  = (state == ST_HOLD);
  assign out.vec    = data;
  assign out.scalar = den;

  // the max lane always adds exp(0), so the sum can never be small
  a_sum_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    in.valid |-> in.scalar >= sum_t'(1 << `SM_EXP_FRAC));

endmodule

/* design/softmax_out_serialize.sv */
`timescale 1ns/1ps
`include "softmax_params.svh"

module softmax_out_serialize (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      run,
  vec_if.dst                        in,
  input  logic                      tx_fifo_en,
  output softmax_pkg::stream_word_t tx_data,
  output logic                      tx_empty
);
  import softmax_pkg::*;

  stream_word_t words [`SM_WORDS];
  logic [4:0]   ptr;  // next word to present
  logic         pop;

  assign in.ready = tx_empty;
  assign pop      = run && tx_fifo_en && !tx_empty;
  assign tx_data  = words[ptr[3:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr      <= '0;
      tx_empty <= 1'b1;
    end else if (in.valid && in.ready) begin
      ptr      <= '0;
      tx_empty <= 1'b0;
    end else if (pop) begin
      ptr <= ptr + 5'd1;
      if (ptr == 5'(`SM_WORDS - 1)) tx_empty <= 1'b1;  // last word gone
    end
  end

  // odd byte high, even byte low
  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      for (int i = 0; i < `SM_WORDS; i++) begin
        words[i] <= {in.vec[2*i+1][`SM_OUT_BITS-1:0], in.vec[2*i][`SM_OUT_BITS-1:0]};
      end
    end
  end

  a_ptr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_empty |-> ptr < 5'(`SM_WORDS));

endmodule

/* design/softmax_top.sv */
`timescale 1ns/1ps

module softmax_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  softmax_pkg::stream_word_t fifo_data,
  input  logic                      fifo_empty,
  output logic                      rd_en,
  output softmax_pkg::stream_word_t tx_data,
  output logic                      tx_empty,
  input  logic                      tx_fifo_en,
  input  logic [1:0]                control
);
  import softmax_pkg::*;

  mode_t        mode;
  logic         run;       // softmax path owns the fifo ports
  logic         core_rd_en;
  stream_word_t core_tx_data;
  logic         core_tx_empty;

  vec_if max_if ();
  vec_if exp_if ();
  vec_if norm_if ();
  vec_if prob_if ();

  assign mode = mode_t'(control);
  assign run  = (mode != MODE_BYPASS);

  softmax_in_collect u_collect (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .rd_en      (core_rd_en),
    .out        (max_if.src)
  );

  softmax_max_find u_max (.clk(clk), .rst_n(rst_n), .in(max_if.dst), .out(exp_if.src));

  softmax_exp_sum u_exp (.clk(clk), .rst_n(rst_n), .in(exp_if.dst), .out(norm_if.src));

  softmax_normalize u_norm (.clk(clk), .rst_n(rst_n), .in(norm_if.dst), .out(prob_if.src));

  softmax_out_serialize u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .in         (prob_if.dst),
    .tx_fifo_en (tx_fifo_en),
    .tx_data    (core_tx_data),
    .tx_empty   (core_tx_empty)
  );

  // bypass joins upstream fifo straight to the downstream port
  assign rd_en    = run ? core_rd_en    : tx_fifo_en;
  assign tx_data  = run ? core_tx_data  : fifo_data;
  assign tx_empty = run ? core_tx_empty : fifo_empty;

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS   = 4,
  parameter int RST_CYCLES  = 8
) (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  // release on a falling edge, away from the flops
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* tb/softmax_tb.sv */
`timescale 1ns/1ps
`include "softmax_params.svh"

module softmax_tb;
  import softmax_pkg::*;

  localparam int VEC_CYCLES     = 800;  // one vector through all five stages, with slack
  localparam int NUM_VECS       = 9;
  localparam int TIMEOUT_CYCLES = NUM_VECS * VEC_CYCLES + 2800;

  logic              clk;
  logic              rst_n;
  stream_word_t      fifo_data;
  logic              fifo_empty;
  logic              rd_en;
  stream_word_t      tx_data;
  logic              tx_empty;
  logic              tx_fifo_en;
  logic [1:0]        control;

  stream_word_t      up_q[$];    // modelled upstream fifo
  stream_word_t      down_q[$];  // words taken at the downstream port
  stream_word_t      exp_q[$];
  logic signed [7:0] elem [`SM_VEC_LEN];
  logic [31:0]       lfsr;
  logic              drain_on;
  int                n_checks;
  int                n_errors;
  int unsigned       cycle_cnt;

  tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

  softmax_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .rd_en      (rd_en),
    .tx_data    (tx_data),
    .tx_empty   (tx_empty),
    .tx_fifo_en (tx_fifo_en),
    .control    (control)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};  // one step per bit
    end
  endtask

  task automatic check_word(input string name, input stream_word_t expected,
                            input stream_word_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("ERROR %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // one clock of the fifo models, inputs change on the falling edge
  task automatic step();
    stream_word_t dropped;
    @(negedge clk);
    fifo_empty = (up_q.size() == 0);
    if (fifo_empty) fifo_data = '0;
    else fifo_data = up_q[0];
    tx_fifo_en = drain_on && !tx_empty;
    if (tx_fifo_en) down_q.push_back(tx_data);  // taken at the coming edge
    #1;
    if (rd_en) dropped = up_q.pop_front();  // consumed at the coming edge
  endtask

  task automatic push_vector();
    for (int w = 0; w < `SM_WORDS; w++) begin
      up_q.push_back({elem[2*w+1], elem[2*w]});
    end
  endtask

  // softmax reference: max, integer offsets, rounded table, floor divide, cap
  task automatic model_vector();
    int    mx;
    int    d;
    int    sum;
    int    e [`SM_VEC_LEN];
    int    q [`SM_VEC_LEN];
    prob_t lo;
    prob_t hi;
    mx  = -128;
    sum = 0;
    for (int i = 0; i < `SM_VEC_LEN; i++) begin
      if (int'(elem[i]) > mx) mx = elem[i];
    end
    for (int i = 0; i < `SM_VEC_LEN; i++) begin
      d = mx - int'(elem[i]);
      if (d < `SM_EXP_DEPTH) e[i] = $rtoi($itor(1 << `SM_EXP_FRAC) * $exp(-$itor(d)) + 0.5);
      else e[i] = 0;
      sum += e[i];
    end
    for (int i = 0; i < `SM_VEC_LEN; i++) begin
      q[i] = (e[i] << `SM_OUT_BITS) / sum;
      if (q[i] > (1 << `SM_OUT_BITS) - 1) q[i] = (1 << `SM_OUT_BITS) - 1;
    end
    for (int w = 0; w < `SM_WORDS; w++) begin
      lo = prob_t'(q[2*w]);
      hi = prob_t'(q[2*w+1]);
      exp_q.push_back({hi, lo});
    end
  endtask

  task automatic collect_words(input string name, input int n);
    int waited;
    int idx;
    waited   = 0;
    idx      = 0;
    drain_on = 1'b1;
    while (down_q.size() < n && waited < (n / `SM_WORDS) * VEC_CYCLES) begin
      step();
      waited++;
    end
    drain_on = 1'b0;
    if (down_q.size() < n) begin
      n_errors++;
      $display("%s: only %0d of %0d words came out of the downstream port",
               name, down_q.size(), n);
    end
    step();
    check_flag({name, " tx_empty after last word"}, 1'b1, tx_empty);
    while (exp_q.size() > 0 && down_q.size() > 0) begin
      check_word($sformatf("%s word %0d", name, idx), exp_q.pop_front(), down_q.pop_front());
      idx++;
    end
    exp_q.delete();
    down_q.delete();
  endtask

  task automatic test_reset();
    step();
    step();
    check_flag("reset tx_empty", 1'b1, tx_empty);
    check_flag("reset rd_en", 1'b0, rd_en);
  endtask

  task automatic test_bypass();
    logic [7:0] lo;
    logic [7:0] hi;
    @(negedge clk);
    control = MODE_BYPASS;
    for (int k = 0; k < 8; k++) begin
      rand_byte(lo);
      rand_byte(hi);
      fifo_data  = {hi, lo};
      fifo_empty = k[0];  // all four flag combinations
      tx_fifo_en = k[1];
      #1;
      check_word("bypass tx_data", {hi, lo}, tx_data);
      check_flag("bypass rd_en", k[1], rd_en);
      check_flag("bypass tx_empty", k[0], tx_empty);
      @(negedge clk);
    end
    control    = MODE_SOFTMAX;
    fifo_empty = 1'b1;
    tx_fifo_en = 1'b0;
    step();
    step();
    check_flag("bypass core idle", 1'b1, tx_empty);
  endtask

  task automatic test_uniform();
    for (int i = 0; i < `SM_VEC_LEN; i++) elem[i] = -8'sd5;
    push_vector();
    // 4096 * 256 / (32 * 4096) = 8 in every byte
    for (int w = 0; w < `SM_WORDS; w++) exp_q.push_back(16'h0808);
    collect_words("uniform", `SM_WORDS);
  endtask

  task automatic test_dominant();
    for (int i = 0; i < `SM_VEC_LEN; i++) elem[i] = (i % 7) - 10;
    elem[13] = 8'sd60;  // offsets of 64 and more for every other lane
    push_vector();
    for (int w = 0; w < `SM_WORDS; w++) begin
      if (w == 6) exp_q.push_back(16'hff00);  // lane 13 is the high byte of word 6
      else exp_q.push_back(16'h0000);
    end
    collect_words("dominant", `SM_WORDS);
  endtask

  task automatic fill_random();
    logic [7:0] b;
    for (int i = 0; i < `SM_VEC_LEN; i++) begin
      rand_byte(b);
      elem[i] = b;
    end
  endtask

  task automatic test_random();
    for (int v = 0; v < 4; v++) begin
      fill_random();
      push_vector();
      model_vector();
      collect_words($sformatf("random %0d", v), `SM_WORDS);
    end
  endtask

  task automatic test_backpressure();
    int waited;
    waited = 0;
    for (int v = 0; v < 3; v++) begin
      fill_random();
      push_vector();
      model_vector();
    end
    while ((up_q.size() > 0 || tx_empty) && waited < 3 * VEC_CYCLES) begin
      step();
      waited++;
    end
    if (up_q.size() > 0 || tx_empty) begin
      n_errors++;
      $display("backpressure: pipeline did not take all three vectors");
    end
    repeat (VEC_CYCLES / 2) step();  // later vectors pile up behind the held one
    check_flag("backpressure output held", 1'b0, tx_empty);
    collect_words("backpressure", 3 * `SM_WORDS);
  endtask

  initial begin
    fifo_data  = '0;
    fifo_empty = 1'b1;
    tx_fifo_en = 1'b0;
    control    = MODE_SOFTMAX;
    drain_on   = 1'b0;
    lfsr       = 32'hffc2;
    n_checks   = 0;
    n_errors   = 0;
    wait (rst_n === 1'b1);
    test_reset();
    test_bypass();
    test_uniform();
    test_dominant();
    test_random();
    test_backpressure();
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* softmax_top.f */
+incdir+design
design/softmax_pkg.sv
design/vec_if.sv
design/softmax_in_collect.sv
design/softmax_max_find.sv
design/softmax_exp_sum.sv
design/softmax_normalize.sv
design/softmax_out_serialize.sv
design/softmax_top.sv
tb/tb_clk_gen.sv
tb/softmax_tb.sv

/* Bender.yml */
package:
  name: softmax

sources:
  - include_dirs:
      - design
    files:
      - design/softmax_pkg.sv
      - design/vec_if.sv
      - design/softmax_in_collect.sv
      - design/softmax_max_find.sv
      - design/softmax_exp_sum.sv
      - design/softmax_normalize.sv
      - design/softmax_out_serialize.sv
      - design/softmax_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_clk_gen.sv
      - tb/softmax_tb.sv
